/* list.f */
rtl/trace_pkg.sv
rtl/isa_pkg.sv
rtl/trace_capture.sv
rtl/insn_decode.sv
rtl/spec_model.sv
rtl/trace_compare.sv
rtl/xcfi_check_top.sv
dv/xcfi_check_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the checker testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps \
    -f list.f \
    --top-module xcfi_check_tb \
    -o xcfi_check_sim

./obj_dir/xcfi_check_sim | tee sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi

/* dv/xcfi_check_tb.sv */
`timescale 1ns/1ps

module xcfi_check_tb
    import trace_pkg::*;
    import isa_pkg::*;
();

    localparam int verdict_latency = 3;
    localparam int verdict_timeout = 20;
    localparam int quiet_cycles    = 8;

    // One table row is one retirement placed on a check edge.
    typedef struct packed {
        logic      valid;
        op_kind_t  kind;
        insn_t     insn;
        xlen_t     rs1;
        xlen_t     rs2;
        reg_addr_t rd_addr;
        logic      trap;
        xlen_t     pc_off;
        xlen_t     rd_flip;
        mismatch_t mask;
    } row_t;

    logic       clock;
    logic       reset;
    trace_rec_t trace;
    verdict_t   verdict;

    row_t     rows[$];
    string    row_names[$];
    verdict_t seen_q[$];
    int       seen_edge_q[$];

    integer seed;
    int     edge_count;
    int     verdict_count;
    int     expected_verdicts;
    int     pass_count;
    int     fail_count;
    logic   test_failed;

    xcfi_check_top i_xcfi_check_top (
        .clock   (clock),
        .reset   (reset),
        .trace   (trace),
        .verdict (verdict)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // Verdicts are collected mid-cycle, tagged with the edge that produced them.
    always @(negedge clock) begin
        if (verdict.valid === 1'b1) begin
            seen_q.push_back(verdict);
            seen_edge_q.push_back(edge_count);
            verdict_count = verdict_count + 1;
        end
    end

    // ------------------------------------------------------------
    // Reference rules.
    // ------------------------------------------------------------

    // Edge n after reset sees window value ((n - 1) mod 16) + 1.
    function automatic logic is_check_edge(input int n);
        return (((n - 1) % check_period) + 1) == check_cycle;
    endfunction

    function automatic xlen_t rotr(input xlen_t x, input int n);
        if (n == 0) begin
            return x;
        end
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic xlen_t rotl(input xlen_t x, input int n);
        if (n == 0) begin
            return x;
        end
        return (x << n) | (x >> (32 - n));
    endfunction

    function automatic xlen_t expected_rd(input op_kind_t kind, input insn_t insn,
                                          input xlen_t a, input xlen_t b);
        xlen_t r;
        case (kind)
            op_add:        r = a + b;
            op_sub:        r = a - b;
            op_xor:        r = a ^ b;
            op_ror:        r = rotr(a, int'(b[4:0]));
            op_rol:        r = rotl(a, int'(b[4:0]));
            op_sha256sig0: r = rotr(a, 7) ^ rotr(a, 18) ^ (a >> 3);
            default:       r = '0;
        endcase
        if (insn[11:7] == 5'd0) begin
            r = '0;
        end
        return r;
    endfunction

    function automatic insn_t encode_r(input funct7_t f7, input funct3_t f3, input reg_addr_t rd);
        return {f7, 5'd2, 5'd1, f3, rd, opcode_op};
    endfunction

    function automatic insn_t encode_sig0(input reg_addr_t rd);
        return {funct12_sha256sig0, 5'd1, funct3_sha256sig0, rd, opcode_op_imm};
    endfunction

    // ------------------------------------------------------------
    // Stimulus helpers.
    // ------------------------------------------------------------

    function automatic trace_rec_t filler_record(input int sample_edge);
        trace_rec_t rec;
        rec.valid     = !is_check_edge(sample_edge);
        rec.order     = {$random(seed), $random(seed)};
        rec.insn      = $random(seed);
        rec.trap      = 1'b0;
        rec.rs1_addr  = rec.insn[19:15];
        rec.rs2_addr  = rec.insn[24:20];
        rec.rs1_rdata = $random(seed);
        rec.rs2_rdata = $random(seed);
        rec.rd_addr   = rec.insn[11:7];
        rec.rd_wdata  = $random(seed);
        rec.pc_rdata  = $random(seed);
        rec.pc_wdata  = $random(seed);
        return rec;
    endfunction

    function automatic trace_rec_t row_record(input row_t row);
        trace_rec_t rec;
        rec.valid     = row.valid;
        rec.order     = {$random(seed), $random(seed)};
        rec.insn      = row.insn;
        rec.trap      = row.trap;
        rec.rs1_addr  = row.insn[19:15];
        rec.rs2_addr  = row.insn[24:20];
        rec.rs1_rdata = row.rs1;
        rec.rs2_rdata = row.rs2;
        rec.rd_addr   = row.rd_addr;
        rec.rd_wdata  = expected_rd(row.kind, row.insn, row.rs1, row.rs2) ^ row.rd_flip;
        rec.pc_rdata  = $random(seed);
        rec.pc_wdata  = rec.pc_rdata + row.pc_off;
        return rec;
    endfunction

    task automatic next_cycle(input trace_rec_t rec);
        trace <= rec;
        @(posedge clock);
        edge_count = edge_count + 1;
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     test, field, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic report_result(input string name);
        if (test_failed) begin
            fail_count = fail_count + 1;
            $display("FAIL %s", name);
        end else begin
            pass_count = pass_count + 1;
            $display("PASS %s", name);
        end
    endtask

    task automatic add_row(input string name, input logic valid, input op_kind_t kind,
                           input insn_t insn, input xlen_t rs1, input xlen_t rs2,
                           input reg_addr_t rd_addr, input logic trap, input xlen_t pc_off,
                           input xlen_t rd_flip, input mismatch_t mask);
        row_t row;
        row = '{valid, kind, insn, rs1, rs2, rd_addr, trap, pc_off, rd_flip, mask};
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    // Mask bits are trap, rd address, rd data, pc write from left to right.
    task automatic load_table();
        add_row("add_ok", 1'b1, op_add, encode_r(funct7_add, funct3_add, 5'd5),
                32'h1234_5678, 32'h0fed_cba9, 5'd5, 1'b0, 32'd4, 32'h0, 4'b0000);
        add_row("sub_ok", 1'b1, op_sub, encode_r(funct7_sub, funct3_sub, 5'd6),
                32'h0000_0010, 32'h0000_0020, 5'd6, 1'b0, 32'd4, 32'h0, 4'b0000);
        add_row("xor_ok", 1'b1, op_xor, encode_r(funct7_xor, funct3_xor, 5'd7),
                32'hdead_beef, 32'hffff_0000, 5'd7, 1'b0, 32'd4, 32'h0, 4'b0000);
        add_row("ror_ok", 1'b1, op_ror, encode_r(funct7_ror, funct3_ror, 5'd8),
                32'h8000_0001, 32'd13, 5'd8, 1'b0, 32'd4, 32'h0, 4'b0000);
        add_row("ror_zero", 1'b1, op_ror, encode_r(funct7_ror, funct3_ror, 5'd9),
                32'hcafe_f00d, 32'hffff_ffe0, 5'd9, 1'b0, 32'd4, 32'h0, 4'b0000);
        add_row("rol_31", 1'b1, op_rol, encode_r(funct7_rol, funct3_rol, 5'd10),
                32'h8765_4321, 32'd31, 5'd10, 1'b0, 32'd4, 32'h0, 4'b0000);
        add_row("sig0_ok", 1'b1, op_sha256sig0, encode_sig0(5'd11),
                32'h6a09_e667, 32'h0, 5'd11, 1'b0, 32'd4, 32'h0, 4'b0000);
        add_row("ror_bad_data", 1'b1, op_ror, encode_r(funct7_ror, funct3_ror, 5'd12),
                32'h0f0f_0f0f, 32'd4, 5'd12, 1'b0, 32'd4, 32'h0000_0100, 4'b0010);
        add_row("rd_addr_bad", 1'b1, op_xor, encode_r(funct7_xor, funct3_xor, 5'd13),
                32'h5555_aaaa, 32'h0f0f_f0f0, 5'd14, 1'b0, 32'd4, 32'h0, 4'b0100);
        add_row("pc_bad", 1'b1, op_add, encode_r(funct7_add, funct3_add, 5'd15),
                32'h0000_0001, 32'h0000_0002, 5'd15, 1'b0, 32'd8, 32'h0, 4'b0001);
        // The core reports rs1 + rs2 as if x0 were writable.
        add_row("x0_write", 1'b1, op_add, encode_r(funct7_add, funct3_add, 5'd0),
                32'h0000_0003, 32'h0000_0004, 5'd0, 1'b0, 32'd4, 32'h0000_0007, 4'b0010);
        // A taken trap leaves for the trap vector with junk in rd data.
        add_row("illegal_trap", 1'b1, op_illegal, encode_r(7'b0000001, 3'b000, 5'd16),
                32'h0000_0007, 32'h0000_0009, 5'd16, 1'b1, 32'h0000_0100, 32'h0000_005a,
                4'b0000);
        add_row("illegal_no_trap", 1'b1, op_illegal, encode_r(7'b0000001, 3'b000, 5'd16),
                32'h0000_0007, 32'h0000_0009, 5'd16, 1'b0, 32'd4, 32'h0, 4'b1000);
        add_row("legal_trap", 1'b1, op_add, encode_r(funct7_add, funct3_add, 5'd17),
                32'h0000_0100, 32'h0000_0200, 5'd17, 1'b1, 32'd4, 32'h0, 4'b1000);
        add_row("no_valid", 1'b0, op_add, encode_r(funct7_add, funct3_add, 5'd18),
                32'h0000_0001, 32'h0000_0001, 5'd18, 1'b0, 32'd4, 32'h0, 4'b0000);
    endtask

    // ------------------------------------------------------------
    // Main sequence.
    // ------------------------------------------------------------

    initial begin : stimulus
        trace_rec_t rec;
        verdict_t   seen;
        int         sample_edge;
        int         seen_edge;
        int         waited;
        int         limit;
        seed              = 94454;
        reset             = 1'b1;
        trace             = '0;
        edge_count        = 0;
        verdict_count     = 0;
        expected_verdicts = 0;
        pass_count        = 0;
        fail_count        = 0;
        load_table();

        repeat (10) @(posedge clock);
        reset <= 1'b0;

        foreach (rows[i]) begin
            test_failed = 1'b0;
            waited = 0;
            while (!is_check_edge(edge_count + 1) && waited < check_period) begin
                next_cycle(filler_record(edge_count + 1));
                waited = waited + 1;
            end
            sample_edge = edge_count + 1;
            rec = row_record(rows[i]);
            next_cycle(rec);

            limit = rows[i].valid ? verdict_timeout : quiet_cycles;
            waited = 0;
            while (seen_q.size() == 0 && waited < limit) begin
                next_cycle(filler_record(edge_count + 1));
                waited = waited + 1;
            end

            if (rows[i].valid) begin
                expected_verdicts = expected_verdicts + 1;
                if (seen_q.size() == 0) begin
                    $display("%s: no verdict arrived within %0d cycles",
                             row_names[i], verdict_timeout);
                    test_failed = 1'b1;
                end else begin
                    seen = seen_q.pop_front();
                    seen_edge = seen_edge_q.pop_front();
                    check_value(row_names[i], "order", rec.order, seen.order);
                    check_value(row_names[i], "pass", 64'(rows[i].mask == '0), 64'(seen.pass));
                    check_value(row_names[i], "mismatch", 64'(rows[i].mask),
                                64'(seen.mismatch));
                    check_value(row_names[i], "latency", 64'(verdict_latency),
                                64'(seen_edge - sample_edge));
                end
            end
            if (seen_q.size() != 0) begin
                $display("%s: a verdict appeared for a retirement that was not checked",
                         row_names[i]);
                test_failed = 1'b1;
                seen_q.delete();
                seen_edge_q.delete();
            end
            report_result(row_names[i]);
        end

        // Let the pipeline drain before counting verdicts.
        waited = 0;
        while (waited < verdict_timeout) begin
            next_cycle(filler_record(edge_count + 1));
            waited = waited + 1;
        end
        test_failed = 1'b0;
        check_value("verdict_count", "count", 64'(expected_verdicts), 64'(verdict_count));
        report_result("verdict_count");

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* rtl/xcfi_check_top.sv */
`timescale 1ns/1ps

module xcfi_check_top
    import trace_pkg::*;
    import isa_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  trace_rec_t trace,
    output verdict_t   verdict
);

    trace_rec_t captured;
    logic       captured_checked;

    decoded_t   decoded;
    trace_rec_t decoded_trace;
    logic       decoded_checked;

    logic       exp_trap;
    reg_addr_t  exp_rd_addr;
    xlen_t      exp_rd_wdata;
    xlen_t      exp_pc_wdata;
    trace_rec_t model_trace;
    logic       model_checked;

    trace_capture i_trace_capture (
        .clock    (clock),
        .reset    (reset),
        .trace    (trace),
        .captured (captured),
        .checked  (captured_checked)
    );

    insn_decode i_insn_decode (
        .clock       (clock),
        .reset       (reset),
        .captured_in (captured),
        .checked_in  (captured_checked),
        .decoded     (decoded),
        .trace_out   (decoded_trace),
        .checked_out (decoded_checked)
    );

    spec_model i_spec_model (
        .clock        (clock),
        .reset        (reset),
        .decoded      (decoded),
        .trace_in     (decoded_trace),
        .checked_in   (decoded_checked),
        .exp_trap     (exp_trap),
        .exp_rd_addr  (exp_rd_addr),
        .exp_rd_wdata (exp_rd_wdata),
        .exp_pc_wdata (exp_pc_wdata),
        .trace_out    (model_trace),
        .checked_out  (model_checked)
    );

    trace_compare i_trace_compare (
        .clock        (clock),
        .reset        (reset),
        .exp_trap     (exp_trap),
        .exp_rd_addr  (exp_rd_addr),
        .exp_rd_wdata (exp_rd_wdata),
        .exp_pc_wdata (exp_pc_wdata),
        .trace_in     (model_trace),
        .checked_in   (model_checked),
        .verdict      (verdict)
    );

endmodule

/* rtl/trace_compare.sv */
`timescale 1ns/1ps

module trace_compare
    import trace_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       exp_trap,
    input  reg_addr_t  exp_rd_addr,
    input  xlen_t      exp_rd_wdata,
    input  xlen_t      exp_pc_wdata,
    input  trace_rec_t trace_in,
    input  logic       checked_in,
    output verdict_t   verdict
);

    mismatch_t mismatch;

    // A trapping instruction retires nothing else worth comparing, so
    // only the trap bit is judged then.
    always_comb begin
        mismatch                = '0;
        mismatch[mismatch_trap] = (trace_in.trap != exp_trap);
        if (!exp_trap) begin
            mismatch[mismatch_rd_addr] = (trace_in.rd_addr != exp_rd_addr);
            mismatch[mismatch_rd_data] = (trace_in.rd_wdata != exp_rd_wdata);
            mismatch[mismatch_pc]      = (trace_in.pc_wdata != exp_pc_wdata);
        end
    end

    // ------------------------------------------------------------
    // Verdict register.
    // ------------------------------------------------------------

    always_ff @(posedge clock) begin
        verdict.order    <= trace_in.order;
        verdict.pass     <= (mismatch == '0);
        verdict.mismatch <= mismatch;
        if (reset) begin
            verdict.valid <= 1'b0;
        end else begin
            // One pulse per checked retirement.
            verdict.valid <= checked_in;
        end
    end

endmodule

/* rtl/spec_model.sv */
`timescale 1ns/1ps

module spec_model
    import trace_pkg::*;
    import isa_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  decoded_t   decoded,
    input  trace_rec_t trace_in,
    input  logic       checked_in,
    output logic       exp_trap,
    output reg_addr_t  exp_rd_addr,
    output xlen_t      exp_rd_wdata,
    output xlen_t      exp_pc_wdata,
    output trace_rec_t trace_out,
    output logic       checked_out
);

    // Rotating a doubled word keeps amount 0 and 31 free of edge cases.
    function automatic xlen_t rotate_right(input xlen_t value, input shamt_t amount);
        logic [63:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[31:0];
    endfunction

    function automatic xlen_t rotate_left(input xlen_t value, input shamt_t amount);
        logic [63:0] doubled;
        doubled = {value, value} << amount;
        return doubled[63:32];
    endfunction

    xlen_t rs1_value;
    xlen_t rs2_value;
    xlen_t result;

    assign rs1_value = trace_in.rs1_rdata;
    assign rs2_value = decoded.uses_rs2 ? trace_in.rs2_rdata : '0;

    always_comb begin
        case (decoded.op)
            op_add:        result = rs1_value + rs2_value;
            op_sub:        result = rs1_value - rs2_value;
            op_xor:        result = rs1_value ^ rs2_value;
            op_ror:        result = rotate_right(rs1_value, rs2_value[4:0]);
            op_rol:        result = rotate_left(rs1_value, rs2_value[4:0]);
            op_sha256sig0: result = rotate_right(rs1_value, 5'd7) ^
                                    rotate_right(rs1_value, 5'd18) ^
                                    (rs1_value >> 3);
            default:       result = '0;
        endcase

        // Writes to x0 are architecturally discarded.
        if (decoded.rd_addr == '0) begin
            result = '0;
        end
    end

    // ------------------------------------------------------------
    // Stage register.
    // ------------------------------------------------------------

    always_ff @(posedge clock) begin
        exp_trap     <= (decoded.op == op_illegal);
        exp_rd_addr  <= decoded.rd_addr;
        exp_rd_wdata <= result;
        exp_pc_wdata <= trace_in.pc_rdata + 32'd4;
        trace_out    <= trace_in;
        if (reset) begin
            trace_out.valid <= 1'b0;
            checked_out     <= 1'b0;
        end else begin
            checked_out <= checked_in;
        end
    end

endmodule

/* rtl/insn_decode.sv */
`timescale 1ns/1ps

module insn_decode
    import trace_pkg::*;
    import isa_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  trace_rec_t captured_in,
    input  logic       checked_in,
    output decoded_t   decoded,
    output trace_rec_t trace_out,
    output logic       checked_out
);

    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    funct12_t funct12;
    decoded_t next_decoded;

    assign opcode  = captured_in.insn[6:0];
    assign funct3  = captured_in.insn[14:12];
    assign funct7  = captured_in.insn[31:25];
    assign funct12 = captured_in.insn[31:20];

    // Anything that does not match one of the supported encodings
    // falls through as illegal.
    always_comb begin
        next_decoded.op       = op_illegal;
        next_decoded.uses_rs2 = 1'b0;
        next_decoded.rd_addr  = captured_in.insn[11:7];

        if (opcode == opcode_op) begin
            if (funct3 == funct3_add && funct7 == funct7_add) begin
                next_decoded.op = op_add;
            end else if (funct3 == funct3_sub && funct7 == funct7_sub) begin
                next_decoded.op = op_sub;
            end else if (funct3 == funct3_xor && funct7 == funct7_xor) begin
                next_decoded.op = op_xor;
            end else if (funct3 == funct3_ror && funct7 == funct7_ror) begin
                next_decoded.op = op_ror;
            end else if (funct3 == funct3_rol && funct7 == funct7_rol) begin
                next_decoded.op = op_rol;
            end
            next_decoded.uses_rs2 = (next_decoded.op != op_illegal);
        end else if (opcode == opcode_op_imm) begin
            if (funct3 == funct3_sha256sig0 && funct12 == funct12_sha256sig0) begin
                next_decoded.op = op_sha256sig0;
            end
        end
    end

    // ------------------------------------------------------------
    // Stage register.
    // ------------------------------------------------------------

    always_ff @(posedge clock) begin
        decoded   <= next_decoded;
        trace_out <= captured_in;
        if (reset) begin
            trace_out.valid <= 1'b0;
            checked_out     <= 1'b0;
        end else begin
            checked_out <= checked_in;
        end
    end

endmodule

/* rtl/trace_capture.sv */
`timescale 1ns/1ps

module trace_capture
    import trace_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  trace_rec_t trace,
    output trace_rec_t captured,
    output logic       checked
);

    // Counts 1 to check_period, so the value seen at the n-th edge after
    // reset is ((n - 1) mod check_period) + 1.
    logic [4:0] cycle_count;

    logic in_window;

    assign in_window = (cycle_count == 5'(check_cycle));

    // ------------------------------------------------------------
    // Check window counter.
    // ------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            cycle_count <= 5'd1;
        end else if (cycle_count == 5'(check_period)) begin
            cycle_count <= 5'd1;
        end else begin
            cycle_count <= cycle_count + 5'd1;
        end
    end

    // ------------------------------------------------------------
    // Trace register.
    // ------------------------------------------------------------

    always_ff @(posedge clock) begin
        captured <= trace;
        if (reset) begin
            captured.valid <= 1'b0;
            checked        <= 1'b0;
        end else begin
            // Only a real retirement inside the window is judged.
            checked <= in_window && trace.valid;
        end
    end

endmodule

/* rtl/isa_pkg.sv */
package isa_pkg;

    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [11:0] funct12_t;
    typedef logic [4:0]  shamt_t;

    // ------------------------------------------------------------
    // Major opcodes.
    // ------------------------------------------------------------

    localparam opcode_t opcode_op     = 7'b0110011;
    localparam opcode_t opcode_op_imm = 7'b0010011;

    // ------------------------------------------------------------
    // Register-register operations.
    // ------------------------------------------------------------

    localparam funct3_t funct3_add = 3'b000;
    localparam funct7_t funct7_add = 7'b0000000;

    localparam funct3_t funct3_sub = 3'b000;
    localparam funct7_t funct7_sub = 7'b0100000;

    localparam funct3_t funct3_xor = 3'b100;
    localparam funct7_t funct7_xor = 7'b0000000;

    // Rotates come from the bit manipulation extension.
    localparam funct3_t funct3_ror = 3'b101;
    localparam funct7_t funct7_ror = 7'b0110000;

    localparam funct3_t funct3_rol = 3'b001;
    localparam funct7_t funct7_rol = 7'b0110000;

    // SHA-256 sigma0 uses the OP-IMM space with a fixed imm field.
    localparam funct3_t  funct3_sha256sig0  = 3'b001;
    localparam funct12_t funct12_sha256sig0 = 12'b0001_0000_0010;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_ror,
        op_rol,
        op_sha256sig0,
        op_illegal
    } op_kind_t;

    typedef struct packed {
        op_kind_t               op;
        logic                   uses_rs2;
        trace_pkg::reg_addr_t   rd_addr;
    } decoded_t;

endpackage

/* rtl/trace_pkg.sv */
package trace_pkg;

    // ------------------------------------------------------------
    // Widths of the retirement trace fields.
    // ------------------------------------------------------------

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] insn_t;
    typedef logic [63:0] order_t;
    typedef logic [4:0]  reg_addr_t;

    // One retirement in every check_period cycles is judged.
    localparam int check_period = 16;
    localparam int check_cycle  = 15;

    // One retirement as reported by the core.
    typedef struct packed {
        logic      valid;
        order_t    order;
        insn_t     insn;
        logic      trap;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        xlen_t     rs1_rdata;
        xlen_t     rs2_rdata;
        reg_addr_t rd_addr;
        xlen_t     rd_wdata;
        xlen_t     pc_rdata;
        xlen_t     pc_wdata;
    } trace_rec_t;

    // ------------------------------------------------------------
    // Verdict record.
    // ------------------------------------------------------------

    typedef logic [3:0] mismatch_t;

    // Bit positions inside mismatch_t.
    localparam int mismatch_trap    = 3;
    localparam int mismatch_rd_addr = 2;
    localparam int mismatch_rd_data = 1;
    localparam int mismatch_pc      = 0;

    typedef struct packed {
        logic      valid;
        order_t    order;
        logic      pass;
        mismatch_t mismatch;
    } verdict_t;

endpackage
